// ==== verilog/pp_macros.svh ====
// Bus widths, DMA limits and the memory window select bit
// shared by the packages, the datapath modules and the testbench

`ifndef PP_MACROS_SVH
`define PP_MACROS_SVH

// Register bus, byte addressed
`define PP_ADRS_W      24
`define PP_DATA_W      32
`define PP_BE_W        4

// Memory bus, word addressed
`define PP_MEM_ADRS_W  20
`define PP_LEN_W       6

// DMA length in words and default burst limit
`define PP_DMA_LEN_W   18
`define PP_BURST_MAX   16

// Register address bit that selects the memory write window
`define PP_WINDOW_BIT  23

`endif

// ==== verilog/pp_bus_pkg.sv ====
// Transfer types for the register bus and the internal memory bus
//   reg_req_t   register access
//   mem_cmd_t   memory burst command
//   mem_wdat_t  one write beat

`include "pp_macros.svh"

package pp_bus_pkg;

  // Register access, held by the master until ack
  typedef struct packed {
    logic                    wr;
    logic [`PP_ADRS_W-1:0]   adrs;
    logic [`PP_BE_W-1:0]     be;
    logic [`PP_DATA_W-1:0]   wd;
  } reg_req_t;

  // Burst command, word address and length in beats
  typedef struct packed {
    logic [`PP_MEM_ADRS_W-1:0] adrs;
    logic [`PP_LEN_W-1:0]      len;
  } mem_cmd_t;

  // Write beat
  typedef struct packed {
    logic [`PP_BE_W-1:0]     be;
    logic [`PP_DATA_W-1:0]   data;
  } mem_wdat_t;

endpackage

// ==== verilog/pp_sys_pkg.sv ====
// System controller types
//   reg_addr_e  register map, word index
//   dma_mode_e  DMA fill patterns
//   dma_cfg_t   DMA configuration passed to the fill engine

`include "pp_macros.svh"

package pp_sys_pkg;

  // Register word index, address bits 4..2
  typedef enum logic [2:0] {
    REG_CTRL     = 3'd0,
    REG_STATUS   = 3'd1,
    REG_INT_MASK = 3'd2,
    REG_TOP_ADRS = 3'd3,
    REG_LENGTH   = 3'd4,
    REG_BE       = 3'd5,
    REG_WD0      = 3'd6,
    REG_WD1      = 3'd7
  } reg_addr_e;

  // Fill pattern
  typedef enum logic [1:0] {
    DMA_FILL = 2'd0,
    DMA_ALT  = 2'd1,
    DMA_INCR = 2'd2
  } dma_mode_e;

  typedef struct packed {
    dma_mode_e                  mode;
    logic [`PP_MEM_ADRS_W-1:0]  top_adrs;
    logic [`PP_DMA_LEN_W-1:0]   length;
    logic [`PP_BE_W-1:0]        be;
    logic [`PP_DATA_W-1:0]      wd0;
    logic [`PP_DATA_W-1:0]      wd1;
  } dma_cfg_t;

endpackage

// ==== verilog/pp_dispatch.sv ====
// Register bus request dispatcher
// Routes accesses to the system controller or to the memory write window

`timescale 1ns/1ps
`include "pp_macros.svh"

module pp_dispatch import pp_bus_pkg::*; (
  input  logic                   clk_core,
  input  logic                   i_reset,
  // Register bus master
  input  logic                   i_req,
  input  reg_req_t               i_reg,
  output logic                   o_ack,
  output logic                   o_rstr,
  output logic [`PP_DATA_W-1:0]  o_rd,
  // System controller
  output logic                   o_sys_req,
  output reg_req_t               o_sys_reg,
  input  logic                   i_sys_ack,
  input  logic                   i_sys_rstr,
  input  logic [`PP_DATA_W-1:0]  i_sys_rd,
  // Memory window, single word writes
  output logic                   o_win_req,
  output mem_cmd_t               o_win_cmd,
  output mem_wdat_t              o_win_wdat,
  input  logic                   i_win_ack,
  output logic                   o_win_wstr,
  input  logic                   i_win_wack
);

  typedef enum logic [1:0] {D_IDLE, D_CMD, D_DATA, D_RACK} disp_state_e;

  disp_state_e state;
  logic        win_sel;
  logic        win_rstr;

  assign win_sel = i_reg.adrs[`PP_WINDOW_BIT];

  // System registers see the request as is
  assign o_sys_req = i_req & ~win_sel;
  assign o_sys_reg = i_reg;

  // Window write, one word at the decoded word address
  assign o_win_req       = (state == D_CMD);
  assign o_win_cmd.adrs  = i_reg.adrs[`PP_MEM_ADRS_W+1:2];
  assign o_win_cmd.len   = {{(`PP_LEN_W-1){1'b0}}, 1'b1};
  assign o_win_wdat.be   = i_reg.be;
  assign o_win_wdat.data = i_reg.wd;
  assign o_win_wstr      = (state == D_DATA);

  // Window reads have no read path, return zero
  assign o_ack  = i_sys_ack | (state == D_RACK) | (o_win_wstr & i_win_wack);
  assign o_rstr = i_sys_rstr | win_rstr;
  assign o_rd   = i_sys_rstr ? i_sys_rd : '0;

  always_ff @(posedge clk_core) begin
    if (i_reset) begin
      state    <= D_IDLE;
      win_rstr <= 1'b0;
    end else begin
      win_rstr <= (state == D_RACK);
      case (state)
        D_IDLE: if (i_req && win_sel) state <= i_reg.wr ? D_CMD : D_RACK;
        D_CMD:  if (i_win_ack) state <= D_DATA;
        D_DATA: if (i_win_wack) state <= D_IDLE;
        default: state <= D_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/pp_sys.sv ====
// System controller
// Register file, DMA start and end control, interrupt level

`timescale 1ns/1ps
`include "pp_macros.svh"

module pp_sys import pp_bus_pkg::*, pp_sys_pkg::*; (
  input  logic                   clk_core,
  input  logic                   i_reset,
  // Register access from the dispatcher
  input  logic                   i_req,
  input  reg_req_t               i_reg,
  output logic                   o_ack,
  output logic                   o_rstr,
  output logic [`PP_DATA_W-1:0]  o_rd,
  // DMA control
  output logic                   o_dma_start,
  output dma_cfg_t               o_dma_cfg,
  input  logic                   i_dma_end,
  // Interrupt
  output logic                   o_int
);

  reg_addr_e              radr;
  logic                   wr_en;
  logic                   int_mask;
  logic                   busy;
  logic                   done;
  logic [`PP_DATA_W-1:0]  rd_mux;

  assign radr  = reg_addr_e'(i_reg.adrs[4:2]);
  // Write takes effect on the edge that raises ack
  assign wr_en = i_req & ~o_ack & i_reg.wr;
  assign o_int = done & int_mask;

  //////////////////////////////////////////////////////////////////////
  // Bus handshake
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_core) begin
    if (i_reset) begin
      o_ack  <= 1'b0;
      o_rstr <= 1'b0;
    end else begin
      o_ack  <= i_req & ~o_ack;
      o_rstr <= o_ack & ~i_reg.wr;
    end
  end

  always_ff @(posedge clk_core) begin
    if (o_ack) o_rd <= rd_mux;
  end

  always_comb begin
    rd_mux = '0;
    case (radr)
      REG_CTRL:     rd_mux[1:0] = o_dma_cfg.mode;
      REG_STATUS:   rd_mux[1:0] = {done, busy};
      REG_INT_MASK: rd_mux[0] = int_mask;
      REG_TOP_ADRS: rd_mux[`PP_MEM_ADRS_W-1:0] = o_dma_cfg.top_adrs;
      REG_LENGTH:   rd_mux[`PP_DMA_LEN_W-1:0] = o_dma_cfg.length;
      REG_BE:       rd_mux[`PP_BE_W-1:0] = o_dma_cfg.be;
      REG_WD0:      rd_mux = o_dma_cfg.wd0;
      REG_WD1:      rd_mux = o_dma_cfg.wd1;
      default:      rd_mux = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // DMA configuration
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_core) begin
    if (wr_en) begin
      case (radr)
        REG_CTRL:     o_dma_cfg.mode     <= dma_mode_e'(i_reg.wd[1:0]);
        REG_TOP_ADRS: o_dma_cfg.top_adrs <= i_reg.wd[`PP_MEM_ADRS_W-1:0];
        REG_LENGTH:   o_dma_cfg.length   <= i_reg.wd[`PP_DMA_LEN_W-1:0];
        REG_BE:       o_dma_cfg.be       <= i_reg.wd[`PP_BE_W-1:0];
        REG_WD0:      o_dma_cfg.wd0      <= i_reg.wd;
        REG_WD1:      o_dma_cfg.wd1      <= i_reg.wd;
        default: ;
      endcase
    end
  end

  // Start, busy/done and mask
  always_ff @(posedge clk_core) begin
    if (i_reset) begin
      o_dma_start <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
      int_mask    <= 1'b0;
    end else begin
      o_dma_start <= 1'b0;
      // start is ignored while a fill runs
      if (wr_en && radr == REG_CTRL && i_reg.wd[4] && !busy) begin
        o_dma_start <= 1'b1;
        busy        <= 1'b1;
        done        <= 1'b0;
      end
      if (wr_en && radr == REG_STATUS && i_reg.wd[1]) done <= 1'b0;
      if (wr_en && radr == REG_INT_MASK) int_mask <= i_reg.wd[0];
      if (i_dma_end) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/pp_dma.sv ====
// DMA fill engine
// Splits the fill length into bursts and generates the beat data

`timescale 1ns/1ps
`include "pp_macros.svh"

module pp_dma import pp_bus_pkg::*, pp_sys_pkg::*; #(
  parameter int BURST_MAX = `PP_BURST_MAX
) (
  input  logic       clk_core,
  input  logic       i_reset,
  // Control from the system controller
  input  logic       i_dma_start,
  input  dma_cfg_t   i_dma_cfg,
  output logic       o_dma_end,
  // Memory port
  output logic       o_req,
  output mem_cmd_t   o_cmd,
  input  logic       i_ack,
  output logic       o_wstr,
  output mem_wdat_t  o_wdat,
  input  logic       i_wack
);

  typedef enum logic [1:0] {S_IDLE, S_CMD, S_DATA, S_DONE} dma_state_e;

  localparam logic [`PP_LEN_W-1:0] BMAX = BURST_MAX[`PP_LEN_W-1:0];

  dma_state_e                 state;
  dma_cfg_t                   cfg;
  logic [`PP_DMA_LEN_W-1:0]   offset;
  logic [`PP_DMA_LEN_W-1:0]   remain;
  logic [`PP_LEN_W-1:0]       burst_len;
  logic [`PP_LEN_W-1:0]       beats;
  logic [`PP_MEM_ADRS_W-1:0]  offset_ext;
  logic [`PP_DATA_W-1:0]      pattern;

  assign burst_len  = (remain > BURST_MAX) ? BMAX : remain[`PP_LEN_W-1:0];
  assign offset_ext = {{(`PP_MEM_ADRS_W-`PP_DMA_LEN_W){1'b0}}, offset};

  // Offset holds the burst start while the command is out
  assign o_req       = (state == S_CMD);
  assign o_cmd.adrs  = cfg.top_adrs + offset_ext;
  assign o_cmd.len   = burst_len;
  assign o_wstr      = (state == S_DATA);
  assign o_wdat.be   = cfg.be;
  assign o_wdat.data = pattern;
  assign o_dma_end   = (state == S_DONE);

  // Beat data from the running word offset
  always_comb begin
    case (cfg.mode)
      DMA_ALT:  pattern = offset[0] ? cfg.wd1 : cfg.wd0;
      DMA_INCR: pattern = cfg.wd0 + {{(`PP_DATA_W-`PP_DMA_LEN_W){1'b0}}, offset};
      default:  pattern = cfg.wd0;
    endcase
  end

  // Configuration held for the whole fill
  always_ff @(posedge clk_core) begin
    if (state == S_IDLE && i_dma_start) cfg <= i_dma_cfg;
  end

  //////////////////////////////////////////////////////////////////////
  // Burst sequencing
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_core) begin
    if (i_reset) begin
      state  <= S_IDLE;
      offset <= '0;
      remain <= '0;
      beats  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_dma_start) begin
            offset <= '0;
            remain <= i_dma_cfg.length;
            // Zero length ends without any burst
            state  <= (i_dma_cfg.length == '0) ? S_DONE : S_CMD;
          end
        end
        S_CMD: begin
          if (i_ack) begin
            beats <= burst_len;
            state <= S_DATA;
          end
        end
        S_DATA: begin
          if (i_wack) begin
            offset <= offset + 1'b1;
            remain <= remain - 1'b1;
            beats  <= beats - 1'b1;
            if (beats == 1) state <= (remain == 1) ? S_DONE : S_CMD;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/pp_mic.sv ====
// Two-port memory interconnect
// Round robin arbitration of write bursts onto the bridge port

`timescale 1ns/1ps
`include "pp_macros.svh"

module pp_mic import pp_bus_pkg::*; (
  input  logic       clk_core,
  input  logic       i_reset,
  // Port 0, DMA
  input  logic       i_req0,
  input  mem_cmd_t   i_cmd0,
  output logic       o_ack0,
  input  logic       i_wstr0,
  input  mem_wdat_t  i_wdat0,
  output logic       o_wack0,
  // Port 1, memory window
  input  logic       i_req1,
  input  mem_cmd_t   i_cmd1,
  output logic       o_ack1,
  input  logic       i_wstr1,
  input  mem_wdat_t  i_wdat1,
  output logic       o_wack1,
  // Bridge
  output logic       o_brg_req,
  output mem_cmd_t   o_brg_cmd,
  input  logic       i_brg_ack,
  output logic       o_brg_wstr,
  output mem_wdat_t  o_brg_wdat,
  input  logic       i_brg_wack
);

  typedef enum logic [1:0] {M_IDLE, M_CMD, M_DATA} mic_state_e;

  mic_state_e            state;
  logic                  gnt;
  logic                  last;
  logic                  pick;
  logic [`PP_LEN_W-1:0]  beats;

  // Both requesting, the port that did not go last wins
  assign pick = (i_req0 & i_req1) ? ~last : i_req1;

  assign o_brg_req  = (state == M_CMD);
  assign o_brg_cmd  = gnt ? i_cmd1 : i_cmd0;
  assign o_brg_wstr = (state == M_DATA) & (gnt ? i_wstr1 : i_wstr0);
  assign o_brg_wdat = gnt ? i_wdat1 : i_wdat0;

  // Acks go to the granted port only
  assign o_ack0  = o_brg_req & i_brg_ack & ~gnt;
  assign o_ack1  = o_brg_req & i_brg_ack & gnt;
  assign o_wack0 = o_brg_wstr & i_brg_wack & ~gnt;
  assign o_wack1 = o_brg_wstr & i_brg_wack & gnt;

  // Grant stays locked from command to final beat
  always_ff @(posedge clk_core) begin
    if (i_reset) begin
      state <= M_IDLE;
      gnt   <= 1'b0;
      last  <= 1'b0;
      beats <= '0;
    end else begin
      case (state)
        M_IDLE: begin
          if (i_req0 || i_req1) begin
            gnt   <= pick;
            state <= M_CMD;
          end
        end
        M_CMD: begin
          if (i_brg_ack) begin
            beats <= o_brg_cmd.len;
            state <= M_DATA;
          end
        end
        M_DATA: begin
          if (o_brg_wstr && i_brg_wack) begin
            beats <= beats - 1'b1;
            if (beats == 1) begin
              last  <= gnt;
              state <= M_IDLE;
            end
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/pp_top.sv ====
// Core top level
// Dispatcher, system controller, DMA fill engine and memory interconnect

`timescale 1ns/1ps
`include "pp_macros.svh"

module pp_top import pp_bus_pkg::*, pp_sys_pkg::*; (
  input  logic                   clk_core,
  input  logic                   i_reset,
  // Register bus
  input  logic                   i_req,
  input  reg_req_t               i_reg,
  output logic                   o_ack,
  output logic                   o_rstr,
  output logic [`PP_DATA_W-1:0]  o_rd,
  // Bridge port
  output logic                   o_brg_req,
  output mem_cmd_t               o_brg_cmd,
  input  logic                   i_brg_ack,
  output logic                   o_brg_wstr,
  output mem_wdat_t              o_brg_wdat,
  input  logic                   i_brg_wack,
  // Interrupt
  output logic                   o_int
);

  //////////////////////////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////////////////////////
  // Dispatcher to system controller
  logic                   w_sys_req;
  reg_req_t               w_sys_reg;
  logic                   w_sys_ack;
  logic                   w_sys_rstr;
  logic [`PP_DATA_W-1:0]  w_sys_rd;
  // Dispatcher to interconnect port 1
  logic                   w_win_req;
  mem_cmd_t               w_win_cmd;
  mem_wdat_t              w_win_wdat;
  logic                   w_win_ack;
  logic                   w_win_wstr;
  logic                   w_win_wack;
  // System controller to DMA
  logic                   w_dma_start;
  dma_cfg_t               w_dma_cfg;
  logic                   w_dma_end;
  // DMA to interconnect port 0
  logic                   w_dma_req;
  mem_cmd_t               w_dma_cmd;
  logic                   w_dma_ack;
  logic                   w_dma_wstr;
  mem_wdat_t              w_dma_wdat;
  logic                   w_dma_wack;

  pp_dispatch u_dispatch (
    .clk_core   (clk_core),
    .i_reset    (i_reset),
    .i_req      (i_req),
    .i_reg      (i_reg),
    .o_ack      (o_ack),
    .o_rstr     (o_rstr),
    .o_rd       (o_rd),
    .o_sys_req  (w_sys_req),
    .o_sys_reg  (w_sys_reg),
    .i_sys_ack  (w_sys_ack),
    .i_sys_rstr (w_sys_rstr),
    .i_sys_rd   (w_sys_rd),
    .o_win_req  (w_win_req),
    .o_win_cmd  (w_win_cmd),
    .o_win_wdat (w_win_wdat),
    .i_win_ack  (w_win_ack),
    .o_win_wstr (w_win_wstr),
    .i_win_wack (w_win_wack)
  );

  pp_sys u_sys (
    .clk_core    (clk_core),
    .i_reset     (i_reset),
    .i_req       (w_sys_req),
    .i_reg       (w_sys_reg),
    .o_ack       (w_sys_ack),
    .o_rstr      (w_sys_rstr),
    .o_rd        (w_sys_rd),
    .o_dma_start (w_dma_start),
    .o_dma_cfg   (w_dma_cfg),
    .i_dma_end   (w_dma_end),
    .o_int       (o_int)
  );

  pp_dma #(
    .BURST_MAX (`PP_BURST_MAX)
  ) u_dma (
    .clk_core    (clk_core),
    .i_reset     (i_reset),
    .i_dma_start (w_dma_start),
    .i_dma_cfg   (w_dma_cfg),
    .o_dma_end   (w_dma_end),
    .o_req       (w_dma_req),
    .o_cmd       (w_dma_cmd),
    .i_ack       (w_dma_ack),
    .o_wstr      (w_dma_wstr),
    .o_wdat      (w_dma_wdat),
    .i_wack      (w_dma_wack)
  );

  pp_mic u_mic (
    .clk_core   (clk_core),
    .i_reset    (i_reset),
    .i_req0     (w_dma_req),
    .i_cmd0     (w_dma_cmd),
    .o_ack0     (w_dma_ack),
    .i_wstr0    (w_dma_wstr),
    .i_wdat0    (w_dma_wdat),
    .o_wack0    (w_dma_wack),
    .i_req1     (w_win_req),
    .i_cmd1     (w_win_cmd),
    .o_ack1     (w_win_ack),
    .i_wstr1    (w_win_wstr),
    .i_wdat1    (w_win_wdat),
    .o_wack1    (w_win_wack),
    .o_brg_req  (o_brg_req),
    .o_brg_cmd  (o_brg_cmd),
    .i_brg_ack  (i_brg_ack),
    .o_brg_wstr (o_brg_wstr),
    .o_brg_wdat (o_brg_wdat),
    .i_brg_wack (i_brg_wack)
  );

endmodule

// ==== sim/pp_assertions.sv ====
// Bridge port protocol assertions, bound to the memory interconnect
//   command held stable while waiting for ack
//   write beats only after the command ack and within its length
//   no new command before the final write ack of a burst

`timescale 1ns/1ps
`include "pp_macros.svh"

module pp_assertions import pp_bus_pkg::*; (
  input logic      clk_core,
  input logic      i_reset,
  input logic      o_brg_req,
  input mem_cmd_t  o_brg_cmd,
  input logic      i_brg_ack,
  input logic      o_brg_wstr,
  input logic      i_brg_wack
);

  int unsigned           err_count = 0;
  logic [`PP_LEN_W-1:0]  beats_left;

  // Beats still owed by the current burst
  always_ff @(posedge clk_core) begin
    if (i_reset) beats_left <= '0;
    else if (o_brg_req && i_brg_ack) beats_left <= o_brg_cmd.len;
    else if (o_brg_wstr && i_brg_wack) beats_left <= beats_left - 1'b1;
  end

  cmd_held: assert property (@(posedge clk_core) disable iff (i_reset)
    o_brg_req && !i_brg_ack |=> o_brg_req && $stable(o_brg_cmd))
    else begin
      err_count++;
      $error("bridge command changed or dropped before ack");
    end

  // Beats belong to an acked command that still owes them
  beat_in_burst: assert property (@(posedge clk_core) disable iff (i_reset)
    o_brg_wstr |-> beats_left != '0)
    else begin
      err_count++;
      $error("write beat issued outside an acked burst");
    end

  // A new command only once all beats of the last one are taken
  burst_done_first: assert property (@(posedge clk_core) disable iff (i_reset)
    o_brg_req |-> beats_left == '0)
    else begin
      err_count++;
      $error("new command raised before the final write ack");
    end

endmodule

bind pp_mic pp_assertions u_assert (.*);

// ==== sim/pp_top_tb.sv ====
// Testbench for the core top level
// Clock and reset, register bus driver, bridge memory model with random
// stalls, reference memory model and the tests with their report

`timescale 1ns/1ps
`include "pp_macros.svh"

module pp_top_tb import pp_bus_pkg::*, pp_sys_pkg::*; ();

  localparam int MAX_LEN = 60;
  // Six fills of up to 60 words at about 10 cycles per word with stalls
  localparam int TIMEOUT_CYCLES = 6 * MAX_LEN * 10 + 2000;
  localparam logic [19:0] WIN_BASE = 20'h80000;
  localparam int N_WIN = 8;

  logic                   clk_core = 1'b0;
  logic                   i_reset;
  logic                   i_req;
  reg_req_t               i_reg;
  logic                   o_ack;
  logic                   o_rstr;
  logic [`PP_DATA_W-1:0]  o_rd;
  logic                   o_brg_req;
  mem_cmd_t               o_brg_cmd;
  logic                   i_brg_ack;
  logic                   o_brg_wstr;
  mem_wdat_t              o_brg_wdat;
  logic                   i_brg_wack;
  logic                   o_int;

  // Bridge memory, reference memory and observed commands
  logic [31:0]  brg_mem [int unsigned];
  logic [31:0]  exp_mem [int unsigned];
  mem_cmd_t     cmd_log [$];
  logic [19:0]  beat_adrs;
  int           ack_wait;
  int           wack_wait;

  int     cycles = 0;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     fails_at_start;
  string  test_name;

  // Scratch values of the test sequence
  logic [31:0]  rd;
  logic [31:0]  wd;
  logic [31:0]  wd1;
  logic [19:0]  top;
  logic [19:0]  wadr;
  logic [3:0]   be;
  int           len;
  int           nwin;

  pp_top dut_i (
    .clk_core   (clk_core),
    .i_reset    (i_reset),
    .i_req      (i_req),
    .i_reg      (i_reg),
    .o_ack      (o_ack),
    .o_rstr     (o_rstr),
    .o_rd       (o_rd),
    .o_brg_req  (o_brg_req),
    .o_brg_cmd  (o_brg_cmd),
    .i_brg_ack  (i_brg_ack),
    .o_brg_wstr (o_brg_wstr),
    .o_brg_wdat (o_brg_wdat),
    .i_brg_wack (i_brg_wack),
    .o_int      (o_int)
  );

  always #5 clk_core = ~clk_core;

  always @(posedge clk_core) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] mask);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bridge model with ack and wack after 0 to 3 extra cycles
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_core) begin
    i_brg_ack  <= 1'b0;
    i_brg_wack <= 1'b0;
    if (o_brg_req && i_brg_ack) begin
      cmd_log.push_back(o_brg_cmd);
      beat_adrs <= o_brg_cmd.adrs;
    end else if (o_brg_req) begin
      if (ack_wait == 0) begin
        i_brg_ack <= 1'b1;
        ack_wait  <= $urandom_range(3, 0);
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
    if (o_brg_wstr && i_brg_wack) begin
      brg_mem[beat_adrs] = merge_bytes(brg_mem.exists(beat_adrs) ? brg_mem[beat_adrs] : '0,
                                       o_brg_wdat.data, o_brg_wdat.be);
      beat_adrs <= beat_adrs + 1'b1;
    end else if (o_brg_wstr) begin
      if (wack_wait == 0) begin
        i_brg_wack <= 1'b1;
        wack_wait  <= $urandom_range(3, 0);
      end else begin
        wack_wait <= wack_wait - 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and report
  //////////////////////////////////////////////////////////////////////
  function automatic int fail_total();
    return errors + dut_i.u_mic.u_assert.err_count;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    fails_at_start = fail_total();
    tests_run++;
  endtask

  task automatic finish_test();
    if (fail_total() == fails_at_start) begin
      $display("Test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED", tests_run, test_name);
    end
  endtask

  // Register bus access with the request held until ack
  task automatic bus_access(input logic wr, input logic [23:0] adrs, input logic [3:0] mask,
                            input logic [31:0] data, output logic [31:0] rdata);
    reg_req_t req;
    req.wr   = wr;
    req.adrs = adrs;
    req.be   = mask;
    req.wd   = data;
    rdata    = '0;
    @(posedge clk_core);
    i_req <= 1'b1;
    i_reg <= req;
    do @(posedge clk_core); while (!o_ack);
    i_req <= 1'b0;
    if (!wr) begin
      do @(posedge clk_core); while (!o_rstr);
      rdata = o_rd;
    end
  endtask

  task automatic reg_write(input reg_addr_e r, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, {19'd0, r, 2'b00}, 4'hf, data, unused);
  endtask

  task automatic reg_read(input reg_addr_e r, output logic [31:0] data);
    bus_access(1'b0, {19'd0, r, 2'b00}, 4'hf, '0, data);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[1]) reg_read(REG_STATUS, st);
  endtask

  function automatic logic [31:0] field_mask(input int r);
    case (r)
      2:       return 32'h1;
      3:       return 32'hfffff;
      4:       return 32'h3ffff;
      5:       return 32'hf;
      default: return 32'hffffffff;
    endcase
  endfunction

  // Program and start a fill, and add its words to the reference
  task automatic start_dma(input int mode, input logic [19:0] dtop, input int dlen,
                           input logic [3:0] dbe, input logic [31:0] d0, input logic [31:0] d1);
    logic [31:0] pat;
    reg_write(REG_TOP_ADRS, dtop);
    reg_write(REG_LENGTH, dlen);
    reg_write(REG_BE, dbe);
    reg_write(REG_WD0, d0);
    reg_write(REG_WD1, d1);
    reg_write(REG_CTRL, 32'h10 | mode);
    for (int off = 0; off < dlen; off++) begin
      case (mode)
        1:       pat = off[0] ? d1 : d0;
        2:       pat = d0 + off;
        default: pat = d0;
      endcase
      exp_mem[dtop + off] = merge_bytes(exp_mem.exists(dtop + off) ? exp_mem[dtop + off] : '0,
                                        pat, dbe);
    end
  endtask

  task automatic random_dma(input int mode, input int min_len);
    top = $urandom_range(20'h7ff00, 0);
    len = $urandom_range(MAX_LEN, min_len);
    be  = $urandom_range(15, 1);
    wd  = $urandom();
    wd1 = $urandom();
    start_dma(mode, top, len, be, wd, wd1);
  endtask

  // DMA bursts lie below the window region
  task automatic verify_bursts(input logic [19:0] dtop, input int dlen);
    logic [19:0] next;
    next = dtop;
    foreach (cmd_log[i]) begin
      if (cmd_log[i].adrs < WIN_BASE) begin
        check("burst address", cmd_log[i].adrs, next);
        check("burst length in range",
              cmd_log[i].len != 0 && cmd_log[i].len <= `PP_BURST_MAX, 1);
        next = next + cmd_log[i].len;
      end
    end
    check("words in bursts", next - dtop, dlen);
  endtask

  task automatic compare_memory();
    foreach (exp_mem[a]) begin
      check($sformatf("write seen at word %h", a), brg_mem.exists(a), 1);
      if (brg_mem.exists(a)) check($sformatf("word %h", a), brg_mem[a], exp_mem[a]);
    end
    foreach (brg_mem[a]) begin
      check($sformatf("write expected at word %h", a), exp_mem.exists(a), 1);
    end
  endtask

  task automatic clear_model();
    brg_mem.delete();
    exp_mem.delete();
    cmd_log.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(6));
    i_reset    = 1'b1;
    i_req      = 1'b0;
    i_reg      = '0;
    i_brg_ack  = 1'b0;
    i_brg_wack = 1'b0;
    ack_wait   = 0;
    wack_wait  = 0;
    beat_adrs  = '0;
    repeat (2) @(posedge clk_core);
    i_reset <= 1'b0;
    @(posedge clk_core);

    start_test("reset state");
    check("o_brg_req", o_brg_req, 0);
    check("o_brg_wstr", o_brg_wstr, 0);
    check("o_ack", o_ack, 0);
    check("o_rstr", o_rstr, 0);
    check("o_int", o_int, 0);
    reg_read(REG_STATUS, rd);
    check("status", rd, 0);
    finish_test();

    start_test("register readback");
    for (int r = 2; r < 8; r++) begin
      wd = $urandom();
      reg_write(reg_addr_e'(r), wd);
      reg_read(reg_addr_e'(r), rd);
      check($sformatf("register %0d", r), rd, wd & field_mask(r));
    end
    finish_test();

    reg_write(REG_INT_MASK, 0);
    for (int m = 0; m < 3; m++) begin
      start_test($sformatf("fill mode %0d", m));
      clear_model();
      // Longer than one burst so the length gets split
      random_dma(m, 17);
      wait_done();
      reg_read(REG_STATUS, rd);
      check("status after fill", rd, 2);
      reg_write(REG_STATUS, 2);
      verify_bursts(top, len);
      compare_memory();
      finish_test();
    end

    start_test("interrupt");
    clear_model();
    reg_write(REG_INT_MASK, 1);
    random_dma(2, 1);
    do @(posedge clk_core); while (!o_int);
    reg_read(REG_STATUS, rd);
    check("status with interrupt", rd, 2);
    reg_write(REG_STATUS, 2);
    @(posedge clk_core);
    check("o_int after clear", o_int, 0);
    reg_write(REG_INT_MASK, 0);
    random_dma(1, 1);
    wait_done();
    check("o_int while masked", o_int, 0);
    reg_write(REG_STATUS, 2);
    compare_memory();
    finish_test();

    start_test("window writes during fill");
    clear_model();
    random_dma(2, 40);
    for (int i = 0; i < N_WIN; i++) begin
      wadr = WIN_BASE | (i << 6) | $urandom_range(63, 0);
      be   = $urandom_range(15, 1);
      wd   = $urandom();
      bus_access(1'b1, {2'b10, wadr, 2'b00}, be, wd, rd);
      exp_mem[wadr] = merge_bytes('0, wd, be);
    end
    wait_done();
    reg_write(REG_STATUS, 2);
    verify_bursts(top, len);
    nwin = 0;
    foreach (cmd_log[i]) begin
      if (cmd_log[i].adrs >= WIN_BASE) begin
        nwin++;
        check("window burst length", cmd_log[i].len, 1);
      end
    end
    check("window commands", nwin, N_WIN);
    compare_memory();
    finish_test();

    $display("Tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, dut_i.u_mic.u_assert.err_count);
    if (fail_total() == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/pp_bus_pkg.sv
verilog/pp_sys_pkg.sv
verilog/pp_dispatch.sv
verilog/pp_sys.sv
verilog/pp_dma.sv
verilog/pp_mic.sv
verilog/pp_top.sv
sim/pp_assertions.sv
sim/pp_top_tb.sv
